// File: sources.f
+incdir+.
rast_pkg.sv
tri_bbox.sv
tri_queue.sv
sample_walker.sv
edge_test.sv
rast_top.sv
tb_rast.sv

// File: tb_rast_model.svh
`ifndef TB_RAST_MODEL_SVH
`define TB_RAST_MODEL_SVH

// Sample step from the one-hot code, bit 0 is an eighth of a pixel
function automatic longint grid_step(input logic [rast_pkg::SS_W-1:0] code);
    longint s;
    s = 0;
    for (int b = 0; b < rast_pkg::SS_W; b++) begin
        if (code[b]) s = longint'(1) << (RADIX - 3 + b);
    end
    return s;
endfunction

// Round toward minus infinity onto the grid
function automatic longint snap_down(input longint v, input longint step);
    longint r;
    r = v % step;
    if (r < 0) r = r + step; // Negative remainder folded up
    return v - r;
endfunction

// Box, walk and inside rules for the triangle in cur_x, cur_y, cur_c
task automatic predict_hits();
    longint step;
    longint min_x;
    longint min_y;
    longint max_x;
    longint max_y;
    longint px;
    longint py;
    longint e;
    int pos;
    int neg;
    step = grid_step(sub_sample);
    min_x = cur_x[0];
    max_x = cur_x[0];
    min_y = cur_y[0];
    max_y = cur_y[0];
    for (int i = 1; i < rast_pkg::VERTS; i++) begin
        if (cur_x[i] < min_x) min_x = cur_x[i];
        if (cur_x[i] > max_x) max_x = cur_x[i];
        if (cur_y[i] < min_y) min_y = cur_y[i];
        if (cur_y[i] > max_y) max_y = cur_y[i];
    end
    min_x = snap_down(min_x, step);
    min_y = snap_down(min_y, step);
    max_x = snap_down(max_x, step);
    max_y = snap_down(max_y, step);
    if (min_x < 0) min_x = 0;
    if (min_y < 0) min_y = 0;
    if (max_x > screen_w) max_x = screen_w; // Empty box simply yields no loop pass
    if (max_y > screen_h) max_y = screen_h;
    py = min_y;
    while (py <= max_y) begin
        px = min_x;
        while (px <= max_x) begin
            pos = 0;
            neg = 0;
            for (int i = 0; i < rast_pkg::VERTS; i++) begin
                e = (cur_x[(i + 1) % 3] - cur_x[i]) * (py - cur_y[i])
                    - (cur_y[(i + 1) % 3] - cur_y[i]) * (px - cur_x[i]);
                if (e > 0) pos++;
                if (e < 0) neg++;
            end
            if (pos == 3 || neg == 3) begin // Either winding
                exp_x.push_back(px);
                exp_y.push_back(py);
                exp_c.push_back({cur_c[2], cur_c[1], cur_c[0]});
            end
            px = px + step;
        end
        py = py + step;
    end
endtask

`endif

// File: tb_rast.sv
`timescale 1ns/1ps

module tb_rast;
    localparam int SIGFIG = rast_pkg::SIGFIG_DEF;
    localparam int RADIX = rast_pkg::RADIX_DEF;
    localparam longint PIX = longint'(1) << RADIX; // One pixel in coordinate units
    localparam int WAIT_LIMIT = 20000;              // Cycles per wait loop

    logic clk;
    logic reset;
    logic signed [SIGFIG-1:0] tri_x [rast_pkg::VERTS-1:0];
    logic signed [SIGFIG-1:0] tri_y [rast_pkg::VERTS-1:0];
    logic [SIGFIG-1:0] tri_color [rast_pkg::COLORS-1:0];
    logic tri_valid;
    logic signed [SIGFIG-1:0] screen_w;
    logic signed [SIGFIG-1:0] screen_h;
    logic [rast_pkg::SS_W-1:0] sub_sample;
    logic halt;
    logic signed [SIGFIG-1:0] hit_x;
    logic signed [SIGFIG-1:0] hit_y;
    logic [SIGFIG-1:0] hit_color [rast_pkg::COLORS-1:0];
    logic hit_valid;

    integer seed;
    longint cur_x [3]; // Triangle about to be sent
    longint cur_y [3];
    logic [SIGFIG-1:0] cur_c [3];
    logic signed [63:0] exp_x [$]; // Expected hits in order
    logic signed [63:0] exp_y [$];
    logic [3*SIGFIG-1:0] exp_c [$];
    logic [2*SIGFIG-1:0] got_xy [$]; // Actual points of the current test
    logic [2*SIGFIG-1:0] saved_xy [$];
    logic signed [63:0] want_x;
    logic signed [63:0] want_y;
    logic [3*SIGFIG-1:0] want_c;
    string cur_test;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    bit halt_seen;
    bit timed_out;

    `include "tb_rast_model.svh"

    rast_top #(
        .SIGFIG(SIGFIG), .RADIX(RADIX), .QUEUE_DEPTH(rast_pkg::QUEUE_DEPTH_DEF)
    ) i_dut (
        .clk, .reset, .tri_x, .tri_y, .tri_color, .tri_valid,
        .screen_w, .screen_h, .sub_sample,
        .halt, .hit_x, .hit_y, .hit_color, .hit_valid
    );

    always #10 clk = ~clk;

    task automatic check_equal(input string what, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
        end
    endtask

    // Output monitor sees the previous cycle's values at each edge
    always @(posedge clk) begin
        if (!reset) begin
            if (halt) halt_seen = 1'b1;
            if (hit_valid) begin
                got_xy.push_back({hit_x, hit_y});
                if (exp_x.size() == 0) begin
                    errors++;
                    $display("%s: hit at x %0d y %0d was not expected", cur_test, hit_x, hit_y);
                end else begin
                    want_x = exp_x.pop_front();
                    want_y = exp_y.pop_front();
                    want_c = exp_c.pop_front();
                    check_equal("hit x", want_x, hit_x);
                    check_equal("hit y", want_y, hit_y);
                    for (int i = 0; i < rast_pkg::COLORS; i++) begin
                        check_equal("hit color", want_c[i*SIGFIG +: SIGFIG], hit_color[i]);
                    end
                end
            end
        end
    end

    function automatic longint rand_range(input longint lo, input longint hi);
        longint r;
        r = {$random(seed)}; // Unsigned 32 bits
        return lo + (r % (hi - lo + 1));
    endfunction

    task automatic set_tri(input longint x0, input longint y0, input longint x1,
                           input longint y1, input longint x2, input longint y2);
        cur_x = '{x0, x1, x2};
        cur_y = '{y0, y1, y2};
        for (int i = 0; i < 3; i++) cur_c[i] = SIGFIG'(rand_range(0, (1 << SIGFIG) - 1));
    endtask

    // Small triangle around a centre a bit beyond the screen
    task automatic random_tri();
        longint cx;
        longint cy;
        cx = rand_range(-3 * PIX, 10 * PIX);
        cy = rand_range(-3 * PIX, 8 * PIX);
        set_tri(cx + rand_range(-2 * PIX, 2 * PIX), cy + rand_range(-2 * PIX, 2 * PIX),
                cx + rand_range(-2 * PIX, 2 * PIX), cy + rand_range(-2 * PIX, 2 * PIX),
                cx + rand_range(-2 * PIX, 2 * PIX), cy + rand_range(-2 * PIX, 2 * PIX));
    endtask

    // One strobe with at least one idle cycle between triangles
    task automatic send_tri();
        int waited;
        waited = 0;
        @(posedge clk);
        while (halt && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                timed_out = 1'b1;
                errors++;
                $display("%s: halt stayed high too long, timed out", cur_test);
            end
            @(posedge clk);
        end
        if (!timed_out) begin
            for (int i = 0; i < 3; i++) begin
                tri_x[i] <= SIGFIG'(cur_x[i]);
                tri_y[i] <= SIGFIG'(cur_y[i]);
                tri_color[i] <= cur_c[i];
            end
            tri_valid <= 1'b1;
            predict_hits();
            @(posedge clk);
            tri_valid <= 1'b0;
        end
    endtask

    // Wait for bbox, queue, walker and edge pipeline to empty
    task automatic drain();
        int idle;
        int waited;
        idle = 0;
        waited = 0;
        while (idle < 4 && !timed_out) begin
            @(posedge clk);
            waited++;
            if (i_dut.box_valid || i_dut.q_valid || i_dut.samp_valid || hit_valid) idle = 0;
            else idle++;
            if (waited > WAIT_LIMIT) begin
                timed_out = 1'b1;
                errors++;
                $display("%s: pipeline never went idle, timed out", cur_test);
            end
        end
        if (exp_x.size() != 0) begin
            errors++;
            $display("%s: %0d expected hits never came out", cur_test, exp_x.size());
            exp_x.delete();
            exp_y.delete();
            exp_c.delete();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = errors;
        got_xy.delete();
        halt_seen = 1'b0;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - test_errors);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    initial begin
        seed = 32'he64e_4e42;
        clk = 1'b0;
        reset = 1'b1;
        tri_valid = 1'b0;
        for (int i = 0; i < 3; i++) begin
            tri_x[i] = '0;
            tri_y[i] = '0;
            tri_color[i] = '0;
        end
        screen_w = SIGFIG'(8 * PIX); // 8 by 6 pixels
        screen_h = SIGFIG'(6 * PIX);
        sub_sample = 4'b1000;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        begin_test("reset_idle");
        repeat (4) begin
            @(posedge clk);
            check_equal("halt", 0, halt);
            check_equal("hit_valid", 0, hit_valid);
        end
        end_test();

        for (int b = 3; b >= 0; b--) begin
            @(posedge clk);
            sub_sample <= 4'b0001 << b;
            begin_test($sformatf("subsample_bit%0d", b));
            repeat (4) begin
                random_tri();
                send_tri();
            end
            drain();
            end_test();
        end

        begin_test("winding");
        set_tri(PIX + rand_range(0, PIX), PIX, 6 * PIX, 2 * PIX, 2 * PIX, 5 * PIX);
        send_tri();
        saved_xy.delete();
        for (int i = 0; i < exp_x.size(); i++) begin // Model points, no hit is out yet
            saved_xy.push_back({exp_x[i][SIGFIG-1:0], exp_y[i][SIGFIG-1:0]});
        end
        drain();
        got_xy.delete();
        set_tri(cur_x[0], cur_y[0], cur_x[2], cur_y[2], cur_x[1], cur_y[1]); // Reversed
        send_tri();
        drain();
        check_equal("hit count", saved_xy.size(), got_xy.size());
        for (int i = 0; i < saved_xy.size() && i < got_xy.size(); i++) begin
            check_equal("point", saved_xy[i], got_xy[i]);
        end
        got_xy.delete();
        set_tri(PIX, PIX, 3 * PIX, 2 * PIX, 5 * PIX, 3 * PIX); // Collinear
        send_tri();
        drain();
        check_equal("degenerate hits", 0, got_xy.size());
        end_test();

        @(posedge clk);
        sub_sample <= 4'b0100;
        begin_test("clipping");
        set_tri(-2 * PIX, -PIX, 3 * PIX, 2 * PIX, -PIX, 4 * PIX);     // Over top left
        send_tri();
        set_tri(6 * PIX, 5 * PIX, 10 * PIX, 4 * PIX, 9 * PIX, 8 * PIX); // Over bottom right
        send_tri();
        set_tri(-4 * PIX, PIX, -2 * PIX, 3 * PIX, -3 * PIX, 4 * PIX);   // Left of screen
        send_tri();
        set_tri(PIX, 8 * PIX, 4 * PIX, 9 * PIX, 2 * PIX, 11 * PIX);     // Below screen
        send_tri();
        set_tri(PIX, PIX, 5 * PIX, 2 * PIX, 3 * PIX, 5 * PIX);          // Follows the culled ones
        send_tri();
        drain();
        end_test();

        @(posedge clk);
        sub_sample <= 4'b0010;
        begin_test("burst");
        repeat (40) begin
            random_tri();
            send_tri();
        end
        drain();
        check_equal("halt raised", 1, halt_seen);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: rast_top.sv
`timescale 1ns/1ps

module rast_top #(
    parameter int SIGFIG = rast_pkg::SIGFIG_DEF,
    parameter int RADIX = rast_pkg::RADIX_DEF,
    parameter int QUEUE_DEPTH = rast_pkg::QUEUE_DEPTH_DEF
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic signed [SIGFIG-1:0]   tri_x [rast_pkg::VERTS-1:0],
    input  logic signed [SIGFIG-1:0]   tri_y [rast_pkg::VERTS-1:0],
    input  logic [SIGFIG-1:0]          tri_color [rast_pkg::COLORS-1:0],
    input  logic                       tri_valid,
    input  logic signed [SIGFIG-1:0]   screen_w, // Configuration levels
    input  logic signed [SIGFIG-1:0]   screen_h,
    input  logic [rast_pkg::SS_W-1:0]  sub_sample,
    output logic                       halt,
    output logic signed [SIGFIG-1:0]   hit_x,
    output logic signed [SIGFIG-1:0]   hit_y,
    output logic [SIGFIG-1:0]          hit_color [rast_pkg::COLORS-1:0],
    output logic                       hit_valid
);
    // Bbox to queue
    logic box_valid;
    logic signed [SIGFIG-1:0] box_tri_x [rast_pkg::VERTS-1:0];
    logic signed [SIGFIG-1:0] box_tri_y [rast_pkg::VERTS-1:0];
    logic [SIGFIG-1:0] box_color [rast_pkg::COLORS-1:0];
    logic signed [SIGFIG-1:0] box_min_x;
    logic signed [SIGFIG-1:0] box_min_y;
    logic signed [SIGFIG-1:0] box_max_x;
    logic signed [SIGFIG-1:0] box_max_y;

    // Queue head to walker
    logic q_valid;
    logic q_pop;
    logic signed [SIGFIG-1:0] q_tri_x [rast_pkg::VERTS-1:0];
    logic signed [SIGFIG-1:0] q_tri_y [rast_pkg::VERTS-1:0];
    logic [SIGFIG-1:0] q_color [rast_pkg::COLORS-1:0];
    logic signed [SIGFIG-1:0] q_min_x;
    logic signed [SIGFIG-1:0] q_min_y;
    logic signed [SIGFIG-1:0] q_max_x;
    logic signed [SIGFIG-1:0] q_max_y;

    // Walker to edge test
    logic samp_valid;
    logic signed [SIGFIG-1:0] samp_x;
    logic signed [SIGFIG-1:0] samp_y;
    logic signed [SIGFIG-1:0] samp_tri_x [rast_pkg::VERTS-1:0];
    logic signed [SIGFIG-1:0] samp_tri_y [rast_pkg::VERTS-1:0];
    logic [SIGFIG-1:0] samp_color [rast_pkg::COLORS-1:0];

    tri_bbox #(.SIGFIG(SIGFIG), .RADIX(RADIX)) i_bbox (
        .clk, .reset, .tri_x, .tri_y, .tri_color, .tri_valid,
        .screen_w, .screen_h, .sub_sample,
        .box_valid, .box_tri_x, .box_tri_y, .box_color,
        .box_min_x, .box_min_y, .box_max_x, .box_max_y
    );

    tri_queue #(.SIGFIG(SIGFIG), .QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
        .clk, .reset, .box_valid, .box_tri_x, .box_tri_y, .box_color,
        .box_min_x, .box_min_y, .box_max_x, .box_max_y, .q_pop,
        .halt, .q_valid, .q_tri_x, .q_tri_y, .q_color,
        .q_min_x, .q_min_y, .q_max_x, .q_max_y
    );

    sample_walker #(.SIGFIG(SIGFIG), .RADIX(RADIX)) i_walker (
        .clk, .reset, .q_valid, .q_tri_x, .q_tri_y, .q_color,
        .q_min_x, .q_min_y, .q_max_x, .q_max_y, .sub_sample,
        .q_pop, .samp_valid, .samp_x, .samp_y,
        .samp_tri_x, .samp_tri_y, .samp_color
    );

    edge_test #(.SIGFIG(SIGFIG)) i_edge (
        .clk, .reset, .samp_valid, .samp_x, .samp_y,
        .samp_tri_x, .samp_tri_y, .samp_color,
        .hit_x, .hit_y, .hit_color, .hit_valid
    );

endmodule

// File: edge_test.sv
`timescale 1ns/1ps

module edge_test #(
    parameter int SIGFIG = rast_pkg::SIGFIG_DEF
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      samp_valid,
    input  logic signed [SIGFIG-1:0]  samp_x,
    input  logic signed [SIGFIG-1:0]  samp_y,
    input  logic signed [SIGFIG-1:0]  samp_tri_x [rast_pkg::VERTS-1:0],
    input  logic signed [SIGFIG-1:0]  samp_tri_y [rast_pkg::VERTS-1:0],
    input  logic [SIGFIG-1:0]         samp_color [rast_pkg::COLORS-1:0],
    output logic signed [SIGFIG-1:0]  hit_x,
    output logic signed [SIGFIG-1:0]  hit_y,
    output logic [SIGFIG-1:0]         hit_color [rast_pkg::COLORS-1:0],
    output logic                      hit_valid
);
    localparam int PW = 2 * SIGFIG + 2; // Product of two differences

    logic signed [SIGFIG:0] dx [rast_pkg::VERTS-1:0];
    logic signed [SIGFIG:0] dy [rast_pkg::VERTS-1:0];
    logic signed [SIGFIG:0] px [rast_pkg::VERTS-1:0]; // Sample relative to edge start
    logic signed [SIGFIG:0] py [rast_pkg::VERTS-1:0];
    logic signed [PW-1:0] prod_a [rast_pkg::VERTS-1:0]; // dx * py
    logic signed [PW-1:0] prod_b [rast_pkg::VERTS-1:0]; // dy * px
    logic signed [PW:0] edge_val [rast_pkg::VERTS-1:0];
    logic s1_valid;
    logic signed [SIGFIG-1:0] s1_x;
    logic signed [SIGFIG-1:0] s1_y;
    logic [SIGFIG-1:0] s1_color [rast_pkg::COLORS-1:0];
    logic all_pos;
    logic all_neg;

    // Edge i runs from vertex i to vertex i+1
    always_comb begin
        for (int i = 0; i < rast_pkg::VERTS; i++) begin
            dx[i] = samp_tri_x[(i + 1) % rast_pkg::VERTS] - samp_tri_x[i];
            dy[i] = samp_tri_y[(i + 1) % rast_pkg::VERTS] - samp_tri_y[i];
            px[i] = samp_x - samp_tri_x[i];
            py[i] = samp_y - samp_tri_y[i];
        end
    end

    // Stage one, products
    always_ff @(posedge clk) begin
        for (int i = 0; i < rast_pkg::VERTS; i++) begin
            prod_a[i] <= dx[i] * py[i];
            prod_b[i] <= dy[i] * px[i];
        end
        s1_x <= samp_x;
        s1_y <= samp_y;
        s1_color <= samp_color;
    end

    // Either winding counts; zero on an edge is a miss
    always_comb begin
        all_pos = 1'b1;
        all_neg = 1'b1;
        for (int i = 0; i < rast_pkg::VERTS; i++) begin
            edge_val[i] = prod_a[i] - prod_b[i];
            if (edge_val[i] <= 0) all_pos = 1'b0;
            if (edge_val[i] >= 0) all_neg = 1'b0;
        end
    end

    // Stage two, hit
    always_ff @(posedge clk) begin
        hit_x <= s1_x;
        hit_y <= s1_y;
        hit_color <= s1_color;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            s1_valid <= samp_valid;
            hit_valid <= s1_valid && (all_pos || all_neg);
        end
    end

endmodule

// File: sample_walker.sv
`timescale 1ns/1ps

module sample_walker #(
    parameter int SIGFIG = rast_pkg::SIGFIG_DEF,
    parameter int RADIX = rast_pkg::RADIX_DEF
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       q_valid,
    input  logic signed [SIGFIG-1:0]   q_tri_x [rast_pkg::VERTS-1:0],
    input  logic signed [SIGFIG-1:0]   q_tri_y [rast_pkg::VERTS-1:0],
    input  logic [SIGFIG-1:0]          q_color [rast_pkg::COLORS-1:0],
    input  logic signed [SIGFIG-1:0]   q_min_x,
    input  logic signed [SIGFIG-1:0]   q_min_y,
    input  logic signed [SIGFIG-1:0]   q_max_x,
    input  logic signed [SIGFIG-1:0]   q_max_y,
    input  logic [rast_pkg::SS_W-1:0]  sub_sample,
    output logic                       q_pop,
    output logic                       samp_valid,
    output logic signed [SIGFIG-1:0]   samp_x,
    output logic signed [SIGFIG-1:0]   samp_y,
    output logic signed [SIGFIG-1:0]   samp_tri_x [rast_pkg::VERTS-1:0],
    output logic signed [SIGFIG-1:0]   samp_tri_y [rast_pkg::VERTS-1:0],
    output logic [SIGFIG-1:0]          samp_color [rast_pkg::COLORS-1:0]
);
    logic walking; // Low is idle
    logic signed [SIGFIG-1:0] step;
    logic signed [SIGFIG-1:0] min_x; // Box of the triangle being walked
    logic signed [SIGFIG-1:0] max_x;
    logic signed [SIGFIG-1:0] max_y;
    logic signed [SIGFIG:0] next_x; // One extra bit so the step cannot wrap
    logic signed [SIGFIG:0] next_y;
    logic last_x;
    logic last_y;

    assign step = SIGFIG'(rast_pkg::ss_step(sub_sample, RADIX));
    assign next_x = samp_x + step;
    assign next_y = samp_y + step;
    assign last_x = (next_x > max_x); // Next step leaves the row
    assign last_y = (next_y > max_y);

    // Take the head only between boxes
    assign q_pop = !walking && q_valid;
    assign samp_valid = walking;

    always_ff @(posedge clk) begin
        if (reset) begin
            walking <= 1'b0;
        end else if (q_pop) begin
            walking <= 1'b1;
        end else if (walking && last_x && last_y) begin
            walking <= 1'b0; // Box maximum reached
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            samp_tri_x <= q_tri_x;
            samp_tri_y <= q_tri_y;
            samp_color <= q_color;
            min_x <= q_min_x;
            max_x <= q_max_x;
            max_y <= q_max_y;
            samp_x <= q_min_x; // First point is the box corner
            samp_y <= q_min_y;
        end else if (walking) begin
            if (last_x) begin
                samp_x <= min_x; // Wrap to the next row
                samp_y <= next_y[SIGFIG-1:0];
            end else begin
                samp_x <= next_x[SIGFIG-1:0];
            end
        end
    end

endmodule

// File: tri_queue.sv
`timescale 1ns/1ps

module tri_queue #(
    parameter int SIGFIG = rast_pkg::SIGFIG_DEF,
    parameter int QUEUE_DEPTH = rast_pkg::QUEUE_DEPTH_DEF
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      box_valid,
    input  logic signed [SIGFIG-1:0]  box_tri_x [rast_pkg::VERTS-1:0],
    input  logic signed [SIGFIG-1:0]  box_tri_y [rast_pkg::VERTS-1:0],
    input  logic [SIGFIG-1:0]         box_color [rast_pkg::COLORS-1:0],
    input  logic signed [SIGFIG-1:0]  box_min_x,
    input  logic signed [SIGFIG-1:0]  box_min_y,
    input  logic signed [SIGFIG-1:0]  box_max_x,
    input  logic signed [SIGFIG-1:0]  box_max_y,
    input  logic                      q_pop,
    output logic                      halt,
    output logic                      q_valid,
    output logic signed [SIGFIG-1:0]  q_tri_x [rast_pkg::VERTS-1:0],
    output logic signed [SIGFIG-1:0]  q_tri_y [rast_pkg::VERTS-1:0],
    output logic [SIGFIG-1:0]         q_color [rast_pkg::COLORS-1:0],
    output logic signed [SIGFIG-1:0]  q_min_x,
    output logic signed [SIGFIG-1:0]  q_min_y,
    output logic signed [SIGFIG-1:0]  q_max_x,
    output logic signed [SIGFIG-1:0]  q_max_y
);
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Entry storage, one slot per boxed triangle
    logic signed [SIGFIG-1:0] mem_tri_x [QUEUE_DEPTH-1:0][rast_pkg::VERTS-1:0];
    logic signed [SIGFIG-1:0] mem_tri_y [QUEUE_DEPTH-1:0][rast_pkg::VERTS-1:0];
    logic [SIGFIG-1:0]        mem_color [QUEUE_DEPTH-1:0][rast_pkg::COLORS-1:0];
    logic signed [SIGFIG-1:0] mem_box [QUEUE_DEPTH-1:0][3:0]; // min x, min y, max x, max y

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign q_valid = (count != '0);
    assign halt = (count >= CNT_W'(QUEUE_DEPTH - 1)); // One slot kept for the bbox stage

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (box_valid) wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (q_pop) rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(box_valid) - CNT_W'(q_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (box_valid) begin
            mem_tri_x[wr_ptr] <= box_tri_x;
            mem_tri_y[wr_ptr] <= box_tri_y;
            mem_color[wr_ptr] <= box_color;
            mem_box[wr_ptr] <= '{box_max_y, box_max_x, box_min_y, box_min_x};
        end
    end

    // Head entry
    assign q_tri_x = mem_tri_x[rd_ptr];
    assign q_tri_y = mem_tri_y[rd_ptr];
    assign q_color = mem_color[rd_ptr];
    assign q_min_x = mem_box[rd_ptr][0];
    assign q_min_y = mem_box[rd_ptr][1];
    assign q_max_x = mem_box[rd_ptr][2];
    assign q_max_y = mem_box[rd_ptr][3];

endmodule

// File: tri_bbox.sv
`timescale 1ns/1ps

module tri_bbox #(
    parameter int SIGFIG = rast_pkg::SIGFIG_DEF,
    parameter int RADIX = rast_pkg::RADIX_DEF
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic signed [SIGFIG-1:0]   tri_x [rast_pkg::VERTS-1:0],
    input  logic signed [SIGFIG-1:0]   tri_y [rast_pkg::VERTS-1:0],
    input  logic [SIGFIG-1:0]          tri_color [rast_pkg::COLORS-1:0],
    input  logic                       tri_valid,
    input  logic signed [SIGFIG-1:0]   screen_w,
    input  logic signed [SIGFIG-1:0]   screen_h,
    input  logic [rast_pkg::SS_W-1:0]  sub_sample,
    output logic                       box_valid,
    output logic signed [SIGFIG-1:0]   box_tri_x [rast_pkg::VERTS-1:0],
    output logic signed [SIGFIG-1:0]   box_tri_y [rast_pkg::VERTS-1:0],
    output logic [SIGFIG-1:0]          box_color [rast_pkg::COLORS-1:0],
    output logic signed [SIGFIG-1:0]   box_min_x,
    output logic signed [SIGFIG-1:0]   box_min_y,
    output logic signed [SIGFIG-1:0]   box_max_x,
    output logic signed [SIGFIG-1:0]   box_max_y
);
    logic signed [SIGFIG-1:0] step;
    logic signed [SIGFIG-1:0] grid_mask; // Clears bits below the step
    logic signed [SIGFIG-1:0] lo_x;
    logic signed [SIGFIG-1:0] lo_y;
    logic signed [SIGFIG-1:0] hi_x;
    logic signed [SIGFIG-1:0] hi_y;
    logic signed [SIGFIG-1:0] clip_min_x;
    logic signed [SIGFIG-1:0] clip_min_y;
    logic signed [SIGFIG-1:0] clip_max_x;
    logic signed [SIGFIG-1:0] clip_max_y;
    logic box_empty;

    assign step = SIGFIG'(rast_pkg::ss_step(sub_sample, RADIX));
    assign grid_mask = ~(step - 1'b1);

    // Vertex extremes per axis
    always_comb begin
        lo_x = tri_x[0];
        hi_x = tri_x[0];
        lo_y = tri_y[0];
        hi_y = tri_y[0];
        for (int i = 1; i < rast_pkg::VERTS; i++) begin
            if (tri_x[i] < lo_x) lo_x = tri_x[i];
            if (tri_x[i] > hi_x) hi_x = tri_x[i];
            if (tri_y[i] < lo_y) lo_y = tri_y[i];
            if (tri_y[i] > hi_y) hi_y = tri_y[i];
        end
    end

    // Snap down to the grid, then clip to the screen
    always_comb begin
        clip_min_x = lo_x & grid_mask; // Two's complement AND rounds toward -inf
        clip_min_y = lo_y & grid_mask;
        clip_max_x = hi_x & grid_mask;
        clip_max_y = hi_y & grid_mask;
        if (clip_min_x[SIGFIG-1]) clip_min_x = '0;
        if (clip_min_y[SIGFIG-1]) clip_min_y = '0;
        if (clip_max_x > screen_w) clip_max_x = screen_w;
        if (clip_max_y > screen_h) clip_max_y = screen_h;
    end

    // Wholly off screen ends up inverted after clipping
    assign box_empty = (clip_min_x > clip_max_x) || (clip_min_y > clip_max_y);

    always_ff @(posedge clk) begin
        if (reset) begin
            box_valid <= 1'b0;
        end else begin
            box_valid <= tri_valid && !box_empty; // Culled triangles stop here
        end
    end

    always_ff @(posedge clk) begin
        if (tri_valid) begin
            box_tri_x <= tri_x;
            box_tri_y <= tri_y;
            box_color <= tri_color;
            box_min_x <= clip_min_x;
            box_min_y <= clip_min_y;
            box_max_x <= clip_max_x;
            box_max_y <= clip_max_y;
        end
    end

endmodule

// File: rast_pkg.sv
package rast_pkg;

    // Fixed point defaults
    localparam int SIGFIG_DEF = 24; // Bits in every coordinate and colour word
    localparam int RADIX_DEF = 10;  // Fraction bits of a coordinate

    // Geometry
    localparam int VERTS = 3;       // Vertices per triangle
    localparam int COLORS = 3;      // Colour channels

    // Subsample code, one hot
    //   bit 3 one pixel, bit 2 half, bit 1 quarter, bit 0 eighth
    localparam int SS_W = 4;

    localparam int QUEUE_DEPTH_DEF = 4; // Boxed triangles held ahead of the walker

    // Sample step in coordinate units for a subsample code
    function automatic int ss_step(input logic [SS_W-1:0] code, input int radix);
        int shift;
        shift = radix; // Non one-hot code falls back to a full pixel
        case (code)
            4'b1000: shift = radix;
            4'b0100: shift = radix - 1;
            4'b0010: shift = radix - 2;
            4'b0001: shift = radix - 3;
            default: shift = radix;
        endcase
        return 1 << shift;
    endfunction

endpackage
